// ==== eq_cfg.svh ====
// Image geometry and pixel width shared by both blur models
// Include wherever the image size or pixel width is needed
`ifndef EQ_CFG_SVH
`define EQ_CFG_SVH

// Image width in pixels
`define IMG_W 8

// Image height in pixels
`define IMG_H 6

// Bits per pixel
`define PIX_W 8

`endif

// ==== pix_pkg.sv ====
// Datapath types for the 3x3 Gaussian blur models
// Shared by the spec model, the line buffer and the row-combine stage
`default_nettype none
`include "eq_cfg.svh"

package pix_pkg;

    typedef logic [`PIX_W-1:0] pixel_t;

    // top + 2*middle + bottom needs two extra bits
    typedef logic [`PIX_W+1:0] colsum_t;

    typedef struct packed {
        logic    emit;
        colsum_t sum;
    } col_tag_t;

    // Nine taps in row-major order with column 2 the newest
    typedef logic [8:0][`PIX_W-1:0] window_t;

    typedef logic [$clog2(`IMG_W)-1:0] xcoord_t;
    typedef logic [$clog2(`IMG_H)-1:0] ycoord_t;

endpackage

`default_nettype wire

// ==== eq_pkg.sv ====
// Types for the equivalence wrapper
// Phase of the check and the cycle counter that stops on completion
`default_nettype none

package eq_pkg;

    typedef enum logic [1:0] {
        RUNNING = 2'd0,
        SETTLE  = 2'd1,
        DONE    = 2'd2
    } phase_t;

    typedef logic [15:0] cycle_t;

endpackage

`default_nettype wire

// ==== stream_fifo.sv ====
// Two-entry valid/ready FIFO for any payload type
// Used on the pixel input and the column-sum slice of model b
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst_init,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);
    payload_t   mem [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    assign in_ready  = (count != 2'd2);
    assign out_valid = (count != 2'd0);
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_init) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== stencil_spec.sv ====
// High-level model a of the 3x3 Gaussian blur over a raster pixel stream
// Keeps two rows and a full window and weights all nine taps directly
`timescale 1ns/1ps
`default_nettype none
`include "eq_cfg.svh"

module stencil_spec (
    input  logic            clk,
    input  logic            rst_init,
    input  pix_pkg::pixel_t in_data,
    input  logic            in_valid,
    output logic            in_ready,
    output pix_pkg::pixel_t out_data,
    output logic            out_valid,
    input  logic            out_ready,
    output logic            done
);
    import pix_pkg::*;

    localparam int SUM_W = `PIX_W + 4;
    localparam int N_OUT = (`IMG_W - 2) * (`IMG_H - 2);
    localparam int CNT_W = $clog2(N_OUT + 1);

    pixel_t           row_top [`IMG_W];
    pixel_t           row_mid [`IMG_W];
    window_t          win;
    window_t          win_next;
    xcoord_t          x;
    ycoord_t          y;
    logic             accept;
    logic             in_pos;
    logic [SUM_W-1:0] wsum;
    logic [CNT_W-1:0] out_cnt;

    // Output register must be free or draining
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;
    assign in_pos   = (x >= xcoord_t'(2)) && (y >= ycoord_t'(2));

    always_comb begin
        for (int r = 0; r < 3; r++) begin
            win_next[r*3]   = win[r*3+1];
            win_next[r*3+1] = win[r*3+2];
        end
        win_next[2] = row_top[x];
        win_next[5] = row_mid[x];
        win_next[8] = in_data;
    end

    // 1 2 1 / 2 4 2 / 1 2 1
    assign wsum = SUM_W'(win_next[0]) + (SUM_W'(win_next[1]) << 1) + SUM_W'(win_next[2])
                + (SUM_W'(win_next[3]) << 1) + (SUM_W'(win_next[4]) << 2)
                + (SUM_W'(win_next[5]) << 1)
                + SUM_W'(win_next[6]) + (SUM_W'(win_next[7]) << 1) + SUM_W'(win_next[8]);

    always_ff @(posedge clk) begin
        if (accept) begin
            win         <= win_next;
            row_top[x]  <= row_mid[x];
            row_mid[x]  <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_init) begin
            x <= '0;
            y <= '0;
        end else if (accept) begin
            if (x == xcoord_t'(`IMG_W - 1)) begin
                x <= '0;
                y <= (y == ycoord_t'(`IMG_H - 1)) ? '0 : y + 1'b1;
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_init) begin
            out_valid <= 1'b0;
        end else if (accept && in_pos) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && in_pos) begin
            out_data <= wsum[SUM_W-1:4];
        end
    end

    // Done the cycle after the last output leaves
    always_ff @(posedge clk) begin
        if (rst_init) begin
            out_cnt <= '0;
            done    <= 1'b0;
        end else if (out_valid && out_ready && !done) begin
            out_cnt <= out_cnt + 1'b1;
            if (out_cnt == CNT_W'(N_OUT - 1)) begin
                done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== line_buffer.sv ====
// Line buffer of model b that turns pixels into weighted vertical column sums
// Each sum is tagged when its column completes a full 3x3 window
`timescale 1ns/1ps
`default_nettype none
`include "eq_cfg.svh"

module line_buffer (
    input  logic              clk,
    input  logic              rst_init,
    input  pix_pkg::pixel_t   in_data,
    input  logic              in_valid,
    output logic              in_ready,
    output pix_pkg::col_tag_t out_data,
    output logic              out_valid,
    input  logic              out_ready
);
    import pix_pkg::*;

    pixel_t  row_top [`IMG_W];
    pixel_t  row_mid [`IMG_W];
    xcoord_t x;
    ycoord_t y;
    logic    accept;
    logic    in_pos;
    colsum_t col_sum;

    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;
    assign in_pos   = (x >= xcoord_t'(2)) && (y >= ycoord_t'(2));

    // Vertical 1 2 1 over the two stored rows and the new pixel
    assign col_sum = colsum_t'(row_top[x]) + (colsum_t'(row_mid[x]) << 1)
                   + colsum_t'(in_data);

    always_ff @(posedge clk) begin
        if (accept) begin
            row_top[x] <= row_mid[x];
            row_mid[x] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_init) begin
            x <= '0;
            y <= '0;
        end else if (accept) begin
            if (x == xcoord_t'(`IMG_W - 1)) begin
                x <= '0;
                y <= (y == ycoord_t'(`IMG_H - 1)) ? '0 : y + 1'b1;
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    // Every pixel in yields one column out whether tagged or not
    always_ff @(posedge clk) begin
        if (rst_init) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_data.emit <= in_pos;
            out_data.sum  <= col_sum;
        end
    end

endmodule

`default_nettype wire

// ==== stencil_impl.sv ====
// Separable 3x3 Gaussian blur of model b built from FIFOs and a line buffer
// Column sums from the line buffer are combined horizontally at the end
`timescale 1ns/1ps
`default_nettype none
`include "eq_cfg.svh"

module stencil_impl (
    input  logic            clk,
    input  logic            rst_init,
    input  pix_pkg::pixel_t in_data,
    input  logic            in_valid,
    output logic            in_ready,
    output pix_pkg::pixel_t out_data,
    output logic            out_valid,
    input  logic            out_ready,
    output logic            done
);
    import pix_pkg::*;

    localparam int SUM_W = `PIX_W + 4;
    localparam int N_OUT = (`IMG_W - 2) * (`IMG_H - 2);
    localparam int CNT_W = $clog2(N_OUT + 1);

    pixel_t           fifo_pix;
    logic             fifo_pix_valid;
    logic             fifo_pix_ready;
    col_tag_t         lb_col;
    logic             lb_valid;
    logic             lb_ready;
    col_tag_t         slice_col;
    logic             slice_valid;
    logic             slice_ready;
    logic             slice_pop;
    colsum_t          col_hist [2];
    logic [SUM_W-1:0] row_sum;
    logic [CNT_W-1:0] out_cnt;

    stream_fifo #(.payload_t(pixel_t)) u_in_fifo (
        .clk       (clk),
        .rst_init  (rst_init),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (fifo_pix),
        .out_valid (fifo_pix_valid),
        .out_ready (fifo_pix_ready)
    );

    line_buffer u_line_buf (
        .clk       (clk),
        .rst_init  (rst_init),
        .in_data   (fifo_pix),
        .in_valid  (fifo_pix_valid),
        .in_ready  (fifo_pix_ready),
        .out_data  (lb_col),
        .out_valid (lb_valid),
        .out_ready (lb_ready)
    );

    stream_fifo #(.payload_t(col_tag_t)) u_slice_fifo (
        .clk       (clk),
        .rst_init  (rst_init),
        .in_data   (lb_col),
        .in_valid  (lb_valid),
        .in_ready  (lb_ready),
        .out_data  (slice_col),
        .out_valid (slice_valid),
        .out_ready (slice_ready)
    );

    // Slice FIFO waits while a result sits unaccepted
    assign slice_ready = !out_valid || out_ready;
    assign slice_pop   = slice_valid && slice_ready;

    // Horizontal 1 2 1 over the two previous columns and the incoming one
    assign row_sum = SUM_W'(col_hist[0]) + (SUM_W'(col_hist[1]) << 1)
                   + SUM_W'(slice_col.sum);

    always_ff @(posedge clk) begin
        if (slice_pop) begin
            col_hist[0] <= col_hist[1];
            col_hist[1] <= slice_col.sum;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_init) begin
            out_valid <= 1'b0;
        end else if (slice_pop && slice_col.emit) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (slice_pop && slice_col.emit) begin
            out_data <= row_sum[SUM_W-1:4];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_init) begin
            out_cnt <= '0;
            done    <= 1'b0;
        end else if (out_valid && out_ready && !done) begin
            out_cnt <= out_cnt + 1'b1;
            if (out_cnt == CNT_W'(N_OUT - 1)) begin
                done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== eq_top.sv ====
// Equivalence wrapper that drives the spec and implementation blur models
// from one stream and tracks the cycle count and phase of the check
`timescale 1ns/1ps
`default_nettype none

module eq_top (
    input  logic            clk,
    input  logic            rst_init,
    input  pix_pkg::pixel_t in_data,
    input  logic            in_valid,
    output logic            in_ready,
    input  logic            out_ready,
    output pix_pkg::pixel_t a_out_data,
    output logic            a_out_valid,
    output pix_pkg::pixel_t b_out_data,
    output logic            b_out_valid,
    output logic            a_done,
    output logic            b_done,
    output eq_pkg::cycle_t  cycle_count,
    output eq_pkg::phase_t  phase
);
    import eq_pkg::*;

    logic a_in_ready;
    logic b_in_ready;
    logic in_fire;
    logic both_done;

    // Both models take a pixel only when both can
    assign in_ready  = a_in_ready && b_in_ready;
    assign in_fire   = in_valid && in_ready;
    assign both_done = a_done && b_done;

    always_ff @(posedge clk) begin
        if (rst_init) begin
            cycle_count <= '0;
        end else if (!both_done) begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_init) begin
            phase <= RUNNING;
        end else begin
            case (phase)
                RUNNING: phase <= both_done ? SETTLE : RUNNING;
                SETTLE:  phase <= DONE;
                default: phase <= DONE;
            endcase
        end
    end

    stencil_spec u_spec_a (
        .clk       (clk),
        .rst_init  (rst_init),
        .in_data   (in_data),
        .in_valid  (in_fire),
        .in_ready  (a_in_ready),
        .out_data  (a_out_data),
        .out_valid (a_out_valid),
        .out_ready (out_ready),
        .done      (a_done)
    );

    stencil_impl u_impl_b (
        .clk       (clk),
        .rst_init  (rst_init),
        .in_data   (in_data),
        .in_valid  (in_fire),
        .in_ready  (b_in_ready),
        .out_data  (b_out_data),
        .out_valid (b_out_valid),
        .out_ready (out_ready),
        .done      (b_done)
    );

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
// Free-running clock for the blur equivalence testbench
// Instantiated once by the testbench top
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// ==== eq_top_tb.sv ====
// Testbench for the blur equivalence wrapper that streams one image from eq_input.txt
// through both models and checks outputs, completion, cycle counter and phase
`timescale 1ns/1ps
`default_nettype none
`include "eq_cfg.svh"

module eq_top_tb;
    import pix_pkg::*;
    import eq_pkg::*;

    localparam int CLK_NS      = 4;
    localparam int RST_CYCLES  = 5;
    localparam int N_IN        = `IMG_W * `IMG_H;
    localparam int N_OUT       = (`IMG_W - 2) * (`IMG_H - 2);
    localparam int WATCHDOG_NS = 20 * N_IN * CLK_NS + 50 * CLK_NS;

    logic   clk;
    logic   rst_init;
    pixel_t in_data;
    logic   in_valid;
    logic   in_ready;
    logic   out_ready;
    pixel_t a_out_data;
    logic   a_out_valid;
    pixel_t b_out_data;
    logic   b_out_valid;
    logic   a_done;
    logic   b_done;
    cycle_t cycle_count;
    phase_t phase;

    pixel_t in_pixels [$];
    pixel_t exp_pixels [$];
    int     seed;
    int     a_idx;
    int     b_idx;
    int     pixel_errors;
    int     count_errors;
    int     phase_errors;
    int     flag_errors;
    int     other_errors;

    tb_clock #(.PERIOD_NS(CLK_NS)) u_clock (.clk(clk));

    eq_top u_dut (
        .clk         (clk),
        .rst_init    (rst_init),
        .in_data     (in_data),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .out_ready   (out_ready),
        .a_out_data  (a_out_data),
        .a_out_valid (a_out_valid),
        .b_out_data  (b_out_data),
        .b_out_valid (b_out_valid),
        .a_done      (a_done),
        .b_done      (b_done),
        .cycle_count (cycle_count),
        .phase       (phase)
    );

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            pixel_errors++;
        end
    endtask

    task automatic check_count(input string name, input cycle_t got, input cycle_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            count_errors++;
        end
    endtask

    task automatic check_phase(input string name, input phase_t got, input phase_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            phase_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            flag_errors++;
        end
    endtask

    // Lines tagged I carry input pixels and lines tagged O expected outputs
    task automatic load_vectors();
        int     fd;
        int     c;
        int     n;
        pixel_t v0;
        pixel_t v1;
        pixel_t v2;
        pixel_t v3;
        fd = $fopen("eq_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the data file eq_input.txt");
            other_errors++;
        end else begin
            c = $fgetc(fd);
            while (c >= 0) begin
                if (c[7:0] == "#") begin
                    while (c >= 0 && c[7:0] != "\n") begin
                        c = $fgetc(fd);
                    end
                end else if (c[7:0] == "I" || c[7:0] == "O") begin
                    n = $fscanf(fd, "%h %h %h %h", v0, v1, v2, v3);
                    if (n != 4) begin
                        $display("Data file line does not hold four hex values");
                        other_errors++;
                    end else if (c[7:0] == "I") begin
                        in_pixels.push_back(v0);
                        in_pixels.push_back(v1);
                        in_pixels.push_back(v2);
                        in_pixels.push_back(v3);
                    end else begin
                        exp_pixels.push_back(v0);
                        exp_pixels.push_back(v1);
                        exp_pixels.push_back(v2);
                        exp_pixels.push_back(v3);
                    end
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
        end
    endtask

    // Random output stalls and input gaps with each pixel offered until taken
    task automatic drive_stream();
        int   idx;
        logic taken;
        idx   = 0;
        taken = 1'b0;
        forever begin
            @(negedge clk);
            out_ready = (($random(seed) & 3) != 0);
            if (taken) begin
                idx++;
                in_valid = 1'b0;
            end
            if (!in_valid && idx < N_IN && (($random(seed) & 3) != 0)) begin
                in_data  = in_pixels[idx];
                in_valid = 1'b1;
            end
            #1;
            taken = in_valid && in_ready;
        end
    endtask

    // Checks stall stability of one output stream and compares each transfer in order
    task automatic track_stream(input string data_name, input string valid_name,
                                input pixel_t data, input logic valid,
                                inout int idx, inout logic hold, inout pixel_t last);
        if (hold) begin
            check_flag(valid_name, valid, 1'b1);
            check_pixel(data_name, data, last);
        end
        if (valid && out_ready) begin
            if (idx < N_OUT) begin
                check_pixel(data_name, data, exp_pixels[idx]);
            end else begin
                $display("%s delivered more than %0d outputs", data_name, N_OUT);
                other_errors++;
            end
            idx++;
        end
        hold = valid && !out_ready;
        last = data;
    endtask

    // Samples mid-cycle when every DUT output has settled
    task automatic monitor_dut();
        cycle_t exp_count;
        phase_t exp_phase;
        logic   prev_both;
        logic   a_hold;
        logic   b_hold;
        pixel_t a_last;
        pixel_t b_last;
        exp_count = '0;
        exp_phase = RUNNING;
        prev_both = 1'b0;
        a_hold    = 1'b0;
        b_hold    = 1'b0;
        a_last    = '0;
        b_last    = '0;
        forever begin
            @(negedge clk);
            #1;
            // Counter and phase react to the done pair seen before the last edge
            if (!prev_both) begin
                exp_count = exp_count + 16'd1;
            end else if (exp_phase == RUNNING) begin
                exp_phase = SETTLE;
            end else begin
                exp_phase = DONE;
            end
            check_count("cycle_count", cycle_count, exp_count);
            check_phase("phase", phase, exp_phase);
            check_flag("a_done", a_done, a_idx == N_OUT);
            check_flag("b_done", b_done, b_idx == N_OUT);
            // A held result in model a blocks the shared input
            if (a_out_valid && !out_ready) begin
                check_flag("in_ready", in_ready, 1'b0);
            end
            prev_both = (a_idx == N_OUT) && (b_idx == N_OUT);
            track_stream("a_out_data", "a_out_valid", a_out_data, a_out_valid,
                         a_idx, a_hold, a_last);
            track_stream("b_out_data", "b_out_valid", b_out_data, b_out_valid,
                         b_idx, b_hold, b_last);
        end
    endtask

    function automatic int total_errors();
        return pixel_errors + count_errors + phase_errors + flag_errors + other_errors;
    endfunction

    task automatic print_counts();
        $display("Error counts: pixel %0d, cycle count %0d, phase %0d, flag %0d, other %0d",
                 pixel_errors, count_errors, phase_errors, flag_errors, other_errors);
    endtask

    initial begin
        seed         = 30003;
        a_idx        = 0;
        b_idx        = 0;
        pixel_errors = 0;
        count_errors = 0;
        phase_errors = 0;
        flag_errors  = 0;
        other_errors = 0;
        rst_init     = 1'b1;
        in_data      = '0;
        in_valid     = 1'b0;
        out_ready    = 1'b0;
        load_vectors();
        if (in_pixels.size() != N_IN || exp_pixels.size() != N_OUT) begin
            $display("Data file held %0d inputs and %0d outputs instead of %0d and %0d",
                     in_pixels.size(), exp_pixels.size(), N_IN, N_OUT);
            other_errors++;
        end else begin
            repeat (RST_CYCLES) @(negedge clk);
            check_flag("a_out_valid", a_out_valid, 1'b0);
            check_flag("b_out_valid", b_out_valid, 1'b0);
            check_flag("a_done", a_done, 1'b0);
            check_flag("b_done", b_done, 1'b0);
            check_phase("phase", phase, RUNNING);
            check_count("cycle_count", cycle_count, '0);
            rst_init = 1'b0;
            fork
                drive_stream();
                monitor_dut();
            join_none
            while (!(a_done && b_done)) begin
                @(negedge clk);
            end
            // Extra cycles let the phase reach DONE with the counter frozen
            repeat (6) @(negedge clk);
            if (a_idx != N_OUT || b_idx != N_OUT) begin
                $display("Output totals were %0d for model a and %0d for model b, not %0d",
                         a_idx, b_idx, N_OUT);
                other_errors++;
            end
        end
        print_counts();
        if (total_errors() == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: both models were not done after %0d ns", WATCHDOG_NS);
        print_counts();
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== eq_input.txt ====
# I: four input pixels in raster order, hex; two lines make one 8-pixel image row
# O: four expected blurred outputs in emission order, hex
# Image row 0
I 00 1B 28 43
I 50 6B 78 93
# Image row 1
I 11 1E 39 46
I 61 6E 89 96
# Image row 2
I 14 2F 3C 97
I 64 7F 8C A7
# Image row 3
I 25 32 4D 5A
I 75 82 9D AA
# Image row 4
I 28 43 50 6B
I 78 93 C0 BB
# Image row 5
I 39 46 61 6E
I 89 96 B1 BE
# Outputs centred on rows 1 to 4, six per row
O 21 39 51 61
O 71 85 2B 47
O 63 6F 7B 8F
O 35 4D 65 75
O 87 9D 3F 53
O 67 7B 93 AB

// ==== eq_top.f ====
+incdir+.
pix_pkg.sv
eq_pkg.sv
stream_fifo.sv
stencil_spec.sv
line_buffer.sv
stencil_impl.sv
eq_top.sv
tb_clock.sv
eq_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the equivalence testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -f eq_top.f --top-module eq_top_tb -o sim_eq_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_eq_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$LOG"; then
    exit 1
fi
exit 0
